/* common/mini2a03_pkg.sv */
package mini2a03_pkg;

  // ======================================================================
  // Status byte layout
  // ======================================================================

  localparam int c_bit = 0;
  localparam int z_bit = 1;
  localparam int v_bit = 6;
  localparam int n_bit = 7;

  // ======================================================================
  // Instruction subset and ALU functions
  // ======================================================================

  typedef enum logic [7:0] {
    op_lda_imm = 8'hA9,
    op_lda_abs = 8'hAD,
    op_ldx_imm = 8'hA2,
    op_sta_abs = 8'h8D,
    op_stx_abs = 8'h8E,
    op_adc_imm = 8'h69,
    op_sbc_imm = 8'hE9,
    op_and_imm = 8'h29,
    op_ora_imm = 8'h09,
    op_eor_imm = 8'h49,
    op_cmp_imm = 8'hC9,
    op_sec     = 8'h38,
    op_clc     = 8'h18,
    op_inx     = 8'hE8,
    op_jmp_abs = 8'h4C
  } opcode_t;

  typedef enum logic [2:0] {
    alu_pass,
    alu_adc,
    alu_sbc,
    alu_and,
    alu_or,
    alu_xor,
    alu_cmp
  } alu_op_t;

  localparam logic [15:0] reset_vector     = 16'hFFFC;  // Low byte here, high byte next.
  localparam logic [15:0] dma_trigger_addr = 16'h4014;
  localparam int          oam_depth        = 256;

endpackage

/* common/mem_bus_if.sv */
interface mem_bus_if;

  logic [15:0] addr;
  logic [7:0]  wr_data;
  logic [7:0]  rd_data;  // Valid in the same cycle as the access.
  logic        write;    // One-cycle strobe.
  logic        active;

  modport requester (
    output addr,
    output wr_data,
    output write,
    output active,
    input  rd_data
  );

  modport responder (
    input  addr,
    input  wr_data,
    input  write,
    input  active,
    output rd_data
  );

endinterface

/* cpu/cpu_alu.sv */
module cpu_alu (
  input  mini2a03_pkg::alu_op_t op,
  input  logic [7:0]            lhs,
  input  logic [7:0]            rhs,
  input  logic                  carry_in,
  output logic [7:0]            result,
  output logic                  carry_out,
  output logic                  overflow,
  output logic                  negative,
  output logic                  zero
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic [7:0] cmp_diff;

  assign sum      = {1'b0, lhs} + {1'b0, rhs} + {8'b0, carry_in};
  assign diff     = {1'b0, lhs} - {1'b0, rhs} - {8'b0, ~carry_in};  // Borrow is inverted carry.
  assign cmp_diff = lhs - rhs;

  always_comb
  begin
    result    = rhs;
    carry_out = carry_in;
    overflow  = 1'b0;
    case (op)
      mini2a03_pkg::alu_adc:
      begin
        result    = sum[7:0];
        carry_out = sum[8];
        overflow  = (lhs[7] == rhs[7]) && (sum[7] != lhs[7]);
      end
      mini2a03_pkg::alu_sbc:
      begin
        result    = diff[7:0];
        carry_out = ~diff[8];
        overflow  = (lhs[7] != rhs[7]) && (diff[7] != lhs[7]);
      end
      mini2a03_pkg::alu_and: result = lhs & rhs;
      mini2a03_pkg::alu_or:  result = lhs | rhs;
      mini2a03_pkg::alu_xor: result = lhs ^ rhs;
      mini2a03_pkg::alu_cmp:
      begin
        result    = cmp_diff;  // Only the flags are kept by the core.
        carry_out = (lhs >= rhs);
      end
      default: result = rhs;
    endcase
  end

  assign negative = result[7];
  assign zero     = (result == 8'h00);

endmodule

/* cpu/cpu_core.sv */
module cpu_core (
  input  logic                G_clock,
  input  logic                G_reset,
  mem_bus_if.requester        bus,
  input  logic                ready,
  output logic                sync
);

  typedef enum logic [2:0] {
    st_vec_lo,
    st_vec_hi,
    st_fetch,
    st_operand,
    st_addr_hi,
    st_data
  } state_t;

  state_t                 state;
  mini2a03_pkg::opcode_t  ir;
  logic [15:0]            pc;
  logic [7:0]             adl;
  logic [7:0]             adh;
  logic [7:0]             a_reg;
  logic [7:0]             x_reg;
  logic [7:0]             status;

  mini2a03_pkg::alu_op_t  alu_op;
  logic [7:0]             alu_rhs;
  logic [7:0]             alu_result;
  logic                   alu_carry;
  logic                   alu_overflow;
  logic                   alu_negative;
  logic                   alu_zero;

  logic                   needs_addr;
  logic                   is_implied;
  logic                   is_store;

  assign needs_addr = ir inside {mini2a03_pkg::op_lda_abs, mini2a03_pkg::op_sta_abs,
                                 mini2a03_pkg::op_stx_abs, mini2a03_pkg::op_jmp_abs};
  assign is_implied = ir inside {mini2a03_pkg::op_sec, mini2a03_pkg::op_clc,
                                 mini2a03_pkg::op_inx};
  assign is_store   = ir inside {mini2a03_pkg::op_sta_abs, mini2a03_pkg::op_stx_abs};

  // ======================================================================
  // ALU hookup
  // ======================================================================

  always_comb
  begin
    case (ir)
      mini2a03_pkg::op_adc_imm: alu_op = mini2a03_pkg::alu_adc;
      mini2a03_pkg::op_sbc_imm: alu_op = mini2a03_pkg::alu_sbc;
      mini2a03_pkg::op_and_imm: alu_op = mini2a03_pkg::alu_and;
      mini2a03_pkg::op_ora_imm: alu_op = mini2a03_pkg::alu_or;
      mini2a03_pkg::op_eor_imm: alu_op = mini2a03_pkg::alu_xor;
      mini2a03_pkg::op_cmp_imm: alu_op = mini2a03_pkg::alu_cmp;
      default:                  alu_op = mini2a03_pkg::alu_pass;
    endcase
  end

  assign alu_rhs = (ir == mini2a03_pkg::op_inx) ? x_reg + 8'd1 : bus.rd_data;

  cpu_alu i_cpu_alu (
    .op        (alu_op),
    .lhs       (a_reg),
    .rhs       (alu_rhs),
    .carry_in  (status[mini2a03_pkg::c_bit]),
    .result    (alu_result),
    .carry_out (alu_carry),
    .overflow  (alu_overflow),
    .negative  (alu_negative),
    .zero      (alu_zero)
  );

  // ======================================================================
  // Bus requests
  // ======================================================================

  always_comb
  begin
    bus.addr    = pc;
    bus.wr_data = a_reg;
    bus.write   = 1'b0;
    bus.active  = ready && G_reset;  // The pending access is simply held while stalled.
    case (state)
      st_vec_lo: bus.addr = mini2a03_pkg::reset_vector;
      st_vec_hi: bus.addr = mini2a03_pkg::reset_vector + 16'd1;
      st_data:
      begin
        bus.addr    = {adh, adl};
        bus.write   = ready && is_store;
        bus.wr_data = (ir == mini2a03_pkg::op_stx_abs) ? x_reg : a_reg;
      end
      default: ;
    endcase
  end

  assign sync = ready && (state == st_fetch);

  // ======================================================================
  // Sequencer
  // ======================================================================

  always_ff @(posedge G_clock or negedge G_reset)
  begin
    if (!G_reset)
    begin
      state  <= st_vec_lo;
      ir     <= mini2a03_pkg::op_clc;
      pc     <= 16'h0000;
      adl    <= 8'h00;
      adh    <= 8'h00;
      a_reg  <= 8'h00;
      x_reg  <= 8'h00;
      status <= 8'h00;
    end
    else if (ready)
    begin
      case (state)
        st_vec_lo:
        begin
          pc[7:0] <= bus.rd_data;
          state   <= st_vec_hi;
        end
        st_vec_hi:
        begin
          pc[15:8] <= bus.rd_data;
          state    <= st_fetch;
        end
        st_fetch:
        begin
          ir    <= mini2a03_pkg::opcode_t'(bus.rd_data);
          pc    <= pc + 16'd1;
          state <= st_operand;
        end
        st_operand:
        begin
          if (needs_addr)
          begin
            adl   <= bus.rd_data;
            pc    <= pc + 16'd1;
            state <= st_addr_hi;
          end
          else
          begin
            if (!is_implied)
              pc <= pc + 16'd1;  // Implied opcodes only do a dummy read.
            state <= st_fetch;
            case (ir)
              mini2a03_pkg::op_sec: status[mini2a03_pkg::c_bit] <= 1'b1;
              mini2a03_pkg::op_clc: status[mini2a03_pkg::c_bit] <= 1'b0;
              mini2a03_pkg::op_inx, mini2a03_pkg::op_ldx_imm: x_reg <= alu_result;
              mini2a03_pkg::op_cmp_imm: ;
              default: a_reg <= alu_result;
            endcase
            if (ir != mini2a03_pkg::op_sec && ir != mini2a03_pkg::op_clc)
            begin
              status[mini2a03_pkg::n_bit] <= alu_negative;
              status[mini2a03_pkg::z_bit] <= alu_zero;
            end
            if (alu_op inside {mini2a03_pkg::alu_adc, mini2a03_pkg::alu_sbc,
                               mini2a03_pkg::alu_cmp})
              status[mini2a03_pkg::c_bit] <= alu_carry;
            if (alu_op inside {mini2a03_pkg::alu_adc, mini2a03_pkg::alu_sbc})
              status[mini2a03_pkg::v_bit] <= alu_overflow;
          end
        end
        st_addr_hi:
        begin
          adh <= bus.rd_data;
          if (ir == mini2a03_pkg::op_jmp_abs)
          begin
            pc    <= {bus.rd_data, adl};
            state <= st_fetch;
          end
          else
          begin
            pc    <= pc + 16'd1;
            state <= st_data;
          end
        end
        default:
        begin
          if (ir == mini2a03_pkg::op_lda_abs)
          begin
            a_reg                       <= alu_result;
            status[mini2a03_pkg::n_bit] <= alu_negative;
            status[mini2a03_pkg::z_bit] <= alu_zero;
          end
          state <= st_fetch;
        end
      endcase
    end
  end

  function automatic logic opcode_known(logic [7:0] value);
    return value inside {
      mini2a03_pkg::op_lda_imm, mini2a03_pkg::op_lda_abs, mini2a03_pkg::op_ldx_imm,
      mini2a03_pkg::op_sta_abs, mini2a03_pkg::op_stx_abs, mini2a03_pkg::op_adc_imm,
      mini2a03_pkg::op_sbc_imm, mini2a03_pkg::op_and_imm, mini2a03_pkg::op_ora_imm,
      mini2a03_pkg::op_eor_imm, mini2a03_pkg::op_cmp_imm, mini2a03_pkg::op_sec,
      mini2a03_pkg::op_clc, mini2a03_pkg::op_inx, mini2a03_pkg::op_jmp_abs};
  endfunction

  // Program memory must only ever hand the sequencer opcodes it can run.
  a_known_opcode: assert property (@(posedge G_clock) disable iff (!G_reset)
    sync |-> opcode_known(bus.rd_data))
    else $error("Unsupported opcode %h fetched at %h.", bus.rd_data, bus.addr);

endmodule

/* source/sprite_dma.sv */
module sprite_dma (
  input  logic          G_clock,
  input  logic          G_reset,
  mem_bus_if.requester  bus,
  input  logic          dma_start,
  input  logic [7:0]    dma_page,
  output logic          dma_busy,
  input  logic [7:0]    oam_addr,
  output logic [7:0]    oam_data
);

  localparam logic [7:0] last_index = 8'(mini2a03_pkg::oam_depth - 1);

  logic [7:0] page;
  logic [7:0] index;
  logic [7:0] oam [mini2a03_pkg::oam_depth];

  // One read per cycle, never a write.
  assign bus.addr    = {page, index};
  assign bus.wr_data = 8'h00;
  assign bus.write   = 1'b0;
  assign bus.active  = dma_busy;

  // ======================================================================
  // Copy control
  // ======================================================================

  always_ff @(posedge G_clock or negedge G_reset)
  begin
    if (!G_reset)
    begin
      dma_busy <= 1'b0;
      index    <= 8'h00;
    end
    else if (dma_start)
    begin
      dma_busy <= 1'b1;
      index    <= 8'h00;
    end
    else if (dma_busy)
    begin
      index <= index + 8'd1;
      if (index == last_index)
        dma_busy <= 1'b0;  // Last byte lands this cycle.
    end
  end

  always_ff @(posedge G_clock)
  begin
    if (dma_start)
      page <= dma_page;
    if (dma_busy)
      oam[index] <= bus.rd_data;
  end

  assign oam_data = oam[oam_addr];

  // The core is stalled for the whole copy, so it cannot retrigger it.
  a_no_restart: assert property (@(posedge G_clock) disable iff (!G_reset)
    dma_start |-> !dma_busy)
    else $error("DMA start while a copy is running.");

endmodule

/* source/bus_arbiter.sv */
module bus_arbiter (
  input  logic          G_clock,
  input  logic          G_reset,
  mem_bus_if.responder  cpu_port,
  mem_bus_if.responder  dma_port,
  mem_bus_if.requester  mem_port,
  input  logic          dma_busy,
  output logic          ready,
  output logic          dma_start,
  output logic [7:0]    dma_page
);

  logic trigger_hit;

  assign trigger_hit = cpu_port.active && cpu_port.write &&
                       (cpu_port.addr == mini2a03_pkg::dma_trigger_addr);

  // The copy begins on the next edge, in the cycle after the store.
  assign dma_start = trigger_hit;
  assign dma_page  = cpu_port.wr_data;
  assign ready     = ~dma_busy;

  // ======================================================================
  // Ownership of the memory bus
  // ======================================================================

  always_comb
  begin
    if (dma_busy)
    begin
      mem_port.addr    = dma_port.addr;
      mem_port.wr_data = dma_port.wr_data;
      mem_port.write   = dma_port.write;
      mem_port.active  = dma_port.active;
    end
    else
    begin
      mem_port.addr    = cpu_port.addr;
      mem_port.wr_data = cpu_port.wr_data;
      mem_port.write   = cpu_port.write && !trigger_hit;  // Trigger never reaches memory.
      mem_port.active  = cpu_port.active && !trigger_hit;
    end
  end

  assign cpu_port.rd_data = mem_port.rd_data;
  assign dma_port.rd_data = mem_port.rd_data;

  // The core must hold its pending access back while stalled.
  a_cpu_quiet: assert property (@(posedge G_clock) disable iff (!G_reset)
    !ready |-> !cpu_port.active)
    else $error("CPU access at %h while the bus belongs to the DMA.", cpu_port.addr);

endmodule

/* source/system_memory.sv */
module system_memory #(
  parameter int ram_bits = 11,
  parameter int rom_bits = 15
) (
  input  logic                G_clock,
  input  logic                G_reset,
  mem_bus_if.responder        bus,
  input  logic                load_write,
  input  logic [rom_bits-1:0] load_addr,
  input  logic [7:0]          load_data
);

  logic [7:0] ram [2**ram_bits];
  logic [7:0] rom [2**rom_bits];
  logic       ram_sel;
  logic       rom_sel;

  assign ram_sel = (bus.addr < 16'h2000);  // Mirrored through the whole window.
  assign rom_sel = bus.addr[15];

  always_ff @(posedge G_clock)
  begin
    if (bus.active && bus.write && ram_sel)
      ram[bus.addr[ram_bits-1:0]] <= bus.wr_data;
    if (!G_reset && load_write)
      rom[load_addr] <= load_data;  // Loader only works while the chip is held.
  end

  always_comb
  begin
    if (ram_sel)
      bus.rd_data = ram[bus.addr[ram_bits-1:0]];
    else if (rom_sel)
      bus.rd_data = rom[bus.addr[rom_bits-1:0]];
    else
      bus.rd_data = 8'h00;
  end

endmodule

/* source/mini2a03_top.sv */
module mini2a03_top #(
  parameter int ram_bits = 11,
  parameter int rom_bits = 15
) (
  input  logic                G_clock,
  input  logic                G_reset,
  input  logic                load_write,
  input  logic [rom_bits-1:0] load_addr,
  input  logic [7:0]          load_data,
  input  logic [7:0]          oam_addr,
  output logic [7:0]          oam_data,
  output logic [15:0]         bus_addr,
  output logic [7:0]          bus_wr_data,
  output logic                bus_write,
  output logic                sync,
  output logic                dma_busy
);

  logic       ready;
  logic       dma_start;
  logic [7:0] dma_page;

  mem_bus_if cpu_port ();
  mem_bus_if dma_port ();
  mem_bus_if mem_port ();

  cpu_core i_cpu_core (
    .G_clock (G_clock),
    .G_reset (G_reset),
    .bus     (cpu_port.requester),
    .ready   (ready),
    .sync    (sync)
  );

  bus_arbiter i_bus_arbiter (
    .G_clock   (G_clock),
    .G_reset   (G_reset),
    .cpu_port  (cpu_port.responder),
    .dma_port  (dma_port.responder),
    .mem_port  (mem_port.requester),
    .dma_busy  (dma_busy),
    .ready     (ready),
    .dma_start (dma_start),
    .dma_page  (dma_page)
  );

  sprite_dma i_sprite_dma (
    .G_clock   (G_clock),
    .G_reset   (G_reset),
    .bus       (dma_port.requester),
    .dma_start (dma_start),
    .dma_page  (dma_page),
    .dma_busy  (dma_busy),
    .oam_addr  (oam_addr),
    .oam_data  (oam_data)
  );

  system_memory #(
    .ram_bits (ram_bits),
    .rom_bits (rom_bits)
  ) i_system_memory (
    .G_clock    (G_clock),
    .G_reset    (G_reset),
    .bus        (mem_port.responder),
    .load_write (load_write),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  // The granted bus as seen by memory.
  assign bus_addr    = mem_port.addr;
  assign bus_wr_data = mem_port.wr_data;
  assign bus_write   = mem_port.write;

endmodule

/* verification/mini2a03_tb.sv */
module mini2a03_tb;

  localparam int          rom_bits     = 15;
  localparam int          body_length  = 200;
  localparam logic [7:0]  source_page  = 8'h03;
  localparam logic [7:0]  sentinel     = 8'hA5;
  localparam logic [15:0] program_base = 16'h8000;

  logic                G_clock;
  logic                G_reset;
  logic                load_write;
  logic [rom_bits-1:0] load_addr;
  logic [7:0]          load_data;
  logic [7:0]          oam_addr;
  logic [7:0]          oam_data;
  logic [15:0]         bus_addr;
  logic [7:0]          bus_wr_data;
  logic                bus_write;
  logic                sync;
  logic                dma_busy;

  logic [7:0]  image [2**rom_bits];  // ROM image, index 0 sits at 8000h.
  logic [7:0]  model_ram [2048];
  logic [7:0]  model_oam [256];
  logic [15:0] stored_addrs [$];
  logic [15:0] expected_addr [$];
  logic [7:0]  expected_data [$];
  int          emit_ptr = 0;
  int          instr_count = 0;
  int          busy_cycles = 0;
  bit          fetch_seen = 0;
  bit          dma_seen = 0;
  bit          writes_done = 0;

  mini2a03_top #(
    .ram_bits (11),
    .rom_bits (rom_bits)
  ) i_mini2a03_top (
    .G_clock     (G_clock),
    .G_reset     (G_reset),
    .load_write  (load_write),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .oam_addr    (oam_addr),
    .oam_data    (oam_data),
    .bus_addr    (bus_addr),
    .bus_wr_data (bus_wr_data),
    .bus_write   (bus_write),
    .sync        (sync),
    .dma_busy    (dma_busy)
  );

  always #50 G_clock = ~G_clock;

  // ======================================================================
  // Failure reporting and compare tasks
  // ======================================================================

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic report_mismatch(input string what);
    $display("ERR %0t: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "Mismatch.");
  endtask

  task automatic check_write(input logic [15:0] addr, input logic [7:0] data);
    logic [15:0] want_addr;
    logic [7:0]  want_data;
    if (expected_addr.size() == 0)
      stop_with_failure($sformatf("A write to %h came after the last expected one.", addr));
    want_addr = expected_addr.pop_front();
    want_data = expected_data.pop_front();
    if (addr !== want_addr || data !== want_data)
      report_mismatch($sformatf("write %h <= %h, expected %h <= %h",
                                addr, data, want_addr, want_data));
  endtask

  task automatic check_oam(input logic [7:0] index, input logic [7:0] data);
    if (data !== model_oam[index])
      report_mismatch($sformatf("OAM[%h] is %h, expected %h", index, data, model_oam[index]));
  endtask

  task automatic check_fetch(input logic [15:0] addr);
    if (addr !== program_base)
      report_mismatch($sformatf("first fetch at %h, expected %h", addr, program_base));
  endtask

  task automatic check_dma_length(input int cycles);
    if (cycles != mini2a03_pkg::oam_depth)
      report_mismatch($sformatf("DMA busy for %0d cycles, expected %0d",
                                cycles, mini2a03_pkg::oam_depth));
  endtask

  // ======================================================================
  // Program generation
  // ======================================================================

  task automatic emit(input logic [7:0] value);
    image[emit_ptr[rom_bits-1:0]] = value;
    emit_ptr++;
  endtask

  task automatic emit_implied(input logic [7:0] opcode);
    emit(opcode);
    instr_count++;
  endtask

  task automatic emit_imm(input logic [7:0] opcode, input logic [7:0] value);
    emit(opcode);
    emit(value);
    instr_count++;
  endtask

  task automatic emit_abs(input logic [7:0] opcode, input logic [15:0] addr);
    emit(opcode);
    emit(addr[7:0]);
    emit(addr[15:8]);
    instr_count++;
  endtask

  task automatic build_program();
    logic [15:0] addr;
    logic [7:0]  value;
    for (int i = 0; i < body_length; i++)
    begin
      value = 8'($urandom);
      addr  = 16'($urandom_range(0, 16'h1FFF));  // Any RAM mirror.
      case ($urandom_range(0, 15))
        0: emit_imm(mini2a03_pkg::op_lda_imm, value);
        1: emit_imm(mini2a03_pkg::op_ldx_imm, value);
        2, 3:
        begin
          emit_abs(mini2a03_pkg::op_sta_abs, addr);
          stored_addrs.push_back(addr);
        end
        4:
        begin
          emit_abs(mini2a03_pkg::op_stx_abs, addr);
          stored_addrs.push_back(addr);
        end
        5:
        begin
          if (stored_addrs.size() > 0)
            emit_abs(mini2a03_pkg::op_lda_abs,
                     stored_addrs[$urandom_range(0, stored_addrs.size() - 1)]);
          else
            emit_imm(mini2a03_pkg::op_lda_imm, value);
        end
        6, 7: emit_imm(mini2a03_pkg::op_adc_imm, value);
        8: emit_imm(mini2a03_pkg::op_sbc_imm, value);
        9: emit_imm(mini2a03_pkg::op_cmp_imm, value);
        10: emit_imm(mini2a03_pkg::op_and_imm, value);
        11: emit_imm(mini2a03_pkg::op_ora_imm, value);
        12: emit_imm(mini2a03_pkg::op_eor_imm, value);
        13: emit_implied(value[0] ? mini2a03_pkg::op_sec : mini2a03_pkg::op_clc);
        14: emit_implied(mini2a03_pkg::op_inx);
        default: emit_abs(mini2a03_pkg::op_jmp_abs, program_base + 16'(emit_ptr) + 16'd3);
      endcase
    end
    // Fill the source page, then start the sprite copy from it.
    for (int j = 0; j < 256; j++)
    begin
      emit_imm(mini2a03_pkg::op_lda_imm, 8'($urandom));
      emit_abs(mini2a03_pkg::op_sta_abs, {source_page, 8'(j)});
    end
    emit_imm(mini2a03_pkg::op_lda_imm, source_page);
    emit_abs(mini2a03_pkg::op_sta_abs, mini2a03_pkg::dma_trigger_addr);
    emit_imm(mini2a03_pkg::op_lda_imm, sentinel);
    emit_abs(mini2a03_pkg::op_sta_abs, 16'h07FF);
    emit_abs(mini2a03_pkg::op_jmp_abs, program_base + 16'(emit_ptr));
    image[15'h7FFC] = program_base[7:0];
    image[15'h7FFD] = program_base[15:8];
  endtask

  // ======================================================================
  // Instruction-level model
  // ======================================================================

  task automatic model_store(input logic [15:0] addr, input logic [7:0] value);
    if (addr == mini2a03_pkg::dma_trigger_addr)
    begin
      for (int i = 0; i < 256; i++)
        model_oam[i] = model_ram[{value[2:0], 8'(i)}];
    end
    else
    begin
      expected_addr.push_back(addr);
      expected_data.push_back(value);
      if (addr < 16'h2000)
        model_ram[addr[10:0]] = value;
    end
  endtask

  task automatic run_model();
    logic [15:0] pc;
    logic [15:0] target;
    logic [7:0]  opcode;
    logic [7:0]  operand;
    logic [7:0]  a;
    logic [7:0]  x;
    int          total;
    logic        carry;
    bit          halted;
    pc     = {image[15'h7FFD], image[15'h7FFC]};
    a      = 8'h00;
    x      = 8'h00;
    carry  = 1'b0;
    halted = 0;
    while (!halted)
    begin
      opcode  = image[pc[14:0]];
      operand = image[pc[14:0] + 15'd1];
      target  = {image[pc[14:0] + 15'd2], operand};
      pc      = pc + 16'd2;  // Most of the subset is two bytes long.
      case (opcode)
        mini2a03_pkg::op_lda_imm: a = operand;
        mini2a03_pkg::op_ldx_imm: x = operand;
        mini2a03_pkg::op_adc_imm:
        begin
          total = a + operand + carry;
          a     = 8'(total);
          carry = (total > 255);
        end
        mini2a03_pkg::op_sbc_imm:
        begin
          total = a + (255 - operand) + carry;  // Ones complement plus carry.
          a     = 8'(total);
          carry = (total > 255);
        end
        mini2a03_pkg::op_and_imm: a = a & operand;
        mini2a03_pkg::op_ora_imm: a = a | operand;
        mini2a03_pkg::op_eor_imm: a = a ^ operand;
        mini2a03_pkg::op_cmp_imm: carry = (a >= operand);
        mini2a03_pkg::op_sec,
        mini2a03_pkg::op_clc:
        begin
          carry = (opcode == mini2a03_pkg::op_sec);
          pc    = pc - 16'd1;
        end
        mini2a03_pkg::op_inx:
        begin
          x  = x + 8'd1;
          pc = pc - 16'd1;
        end
        mini2a03_pkg::op_lda_abs:
        begin
          a  = model_ram[target[10:0]];
          pc = pc + 16'd1;
        end
        mini2a03_pkg::op_sta_abs,
        mini2a03_pkg::op_stx_abs:
        begin
          model_store(target, (opcode == mini2a03_pkg::op_stx_abs) ? x : a);
          pc = pc + 16'd1;
        end
        mini2a03_pkg::op_jmp_abs:
        begin
          halted = (target == pc - 16'd2);  // Jump to itself ends the program.
          pc     = target;
        end
        default: stop_with_failure("The model met an opcode outside the supported subset.");
      endcase
    end
  endtask

  // ======================================================================
  // Stimulus, monitor and watchdog
  // ======================================================================

  task automatic load_byte(input int addr, input logic [7:0] data);
    @(posedge G_clock);
    load_write <= 1'b1;
    load_addr  <= addr[rom_bits-1:0];
    load_data  <= data;
  endtask

  initial
  begin
    G_clock    = 1'b0;
    G_reset    = 1'b0;
    load_write = 1'b0;
    load_addr  = '0;
    load_data  = 8'h00;
    oam_addr   = 8'h00;
    void'($urandom(32'hd7ad10f5));
    build_program();
    run_model();
    // The ROM loader only works in reset, so reset covers the load.
    for (int k = 0; k < emit_ptr; k++)
      load_byte(k, image[k]);
    load_byte(16'h7FFC, image[15'h7FFC]);
    load_byte(16'h7FFD, image[15'h7FFD]);
    @(posedge G_clock);
    load_write <= 1'b0;
    repeat (16) @(posedge G_clock);
    G_reset <= 1'b1;
    wait (writes_done);
    if (!dma_seen)
      stop_with_failure("The sprite DMA never ran.");
    else
    begin
      for (int k = 0; k < 256; k++)
      begin
        @(posedge G_clock);
        oam_addr <= 8'(k);
        @(negedge G_clock);
        check_oam(8'(k), oam_data);
      end
      $display("*** PASSED ***");
      $finish;
    end
  end

  always @(negedge G_clock)
  begin
    if (G_reset)
    begin
      if (sync && !fetch_seen)
      begin
        fetch_seen = 1;
        check_fetch(bus_addr);
      end
      if (dma_busy)
      begin
        busy_cycles++;
        if (sync || bus_write)
          stop_with_failure("The core fetched or wrote while the DMA owned the bus.");
      end
      else if (busy_cycles != 0)
      begin
        check_dma_length(busy_cycles);
        busy_cycles = 0;
        dma_seen    = 1;
      end
      if (bus_write)
      begin
        check_write(bus_addr, bus_wr_data);
        if (expected_addr.size() == 0)
          writes_done = 1;  // The sentinel was the last one.
      end
    end
  end

  initial
  begin
    wait (G_reset === 1'b1);
    repeat (instr_count * 4 + 256 + 100) @(posedge G_clock);
    stop_with_failure("Timeout: the program did not finish before the watchdog expired.");
  end

endmodule

/* mini2a03.f */
common/mini2a03_pkg.sv
common/mem_bus_if.sv
cpu/cpu_alu.sv
cpu/cpu_core.sv
source/sprite_dma.sv
source/bus_arbiter.sv
source/system_memory.sv
source/mini2a03_top.sv
verification/mini2a03_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module mini2a03_tb -f mini2a03.f -o mini2a03_sim

./obj_dir/mini2a03_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi
